// ==== common/mips_isa_pkg.sv ====
// Word and register types, instruction field helpers, opcode and funct codes
`default_nettype none

package mips_isa_pkg;

    typedef logic [31:0] word_t;      // Data or address word
    typedef logic [4:0]  reg_addr_t;  // Register number
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm16_t;

    // Major opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_LUI   = 6'h0f;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

    localparam reg_addr_t REG_V0 = 5'd2;
    localparam word_t NOP_INSTR = 32'h0000_0000;  // sll $0, $0, 0

    function automatic opcode_t instr_opcode(input word_t instr);
        return instr[31:26];
    endfunction

    function automatic reg_addr_t instr_rs(input word_t instr);
        return instr[25:21];
    endfunction

    function automatic reg_addr_t instr_rt(input word_t instr);
        return instr[20:16];
    endfunction

    function automatic reg_addr_t instr_rd(input word_t instr);
        return instr[15:11];
    endfunction

    function automatic funct_t instr_funct(input word_t instr);
        return instr[5:0];
    endfunction

    function automatic imm16_t instr_imm(input word_t instr);
        return instr[15:0];
    endfunction

endpackage

`default_nettype wire

// ==== common/mips_pipe_pkg.sv ====
// ALU operation codes, fetch run state and reset vector
`default_nettype none

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    typedef logic [2:0] alu_ctrl_t;

    localparam alu_ctrl_t ALU_ADD = 3'd0;
    localparam alu_ctrl_t ALU_SUB = 3'd1;
    localparam alu_ctrl_t ALU_AND = 3'd2;
    localparam alu_ctrl_t ALU_OR  = 3'd3;
    localparam alu_ctrl_t ALU_SLT = 3'd4;  // Signed compare
    localparam alu_ctrl_t ALU_LUI = 3'd5;  // Immediate into upper half

    // Fetch state, HALTED only left by reset
    typedef enum logic {
        RUNNING,
        HALTED
    } run_state_t;

    localparam word_t RESET_VECTOR = 32'hBFC0_0000;

endpackage

`default_nettype wire

// ==== fetch/fetch_stage.sv ====
// PC register, next PC selection, fetch/decode register and run/halt state
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
    parameter word_t RESET_PC = RESET_VECTOR
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  clk_enable,
    input  logic  stall_f,
    input  logic  stall_d,
    input  logic  pc_src_d,
    input  logic  halt_d,
    input  word_t branch_target_d,
    input  word_t instr_readdata,
    output word_t instr_address,
    output word_t instr_d,
    output word_t pc_plus4_d,
    output logic  running
);

    word_t      pc;
    word_t      pc_plus4;
    run_state_t state;

    assign pc_plus4      = pc + 32'd4;
    assign instr_address = pc;
    assign running       = (state == RUNNING);

    // A stalled decode keeps its branch, so pc_src_d is ignored while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (clk_enable && running && !stall_f) begin
            pc <= pc_src_d ? branch_target_d : pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RUNNING;
        end else if (clk_enable && halt_d && !stall_d) begin
            state <= HALTED;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            instr_d <= NOP_INSTR;
        end else if (clk_enable && !stall_d) begin
            if (pc_src_d || halt_d || !running) begin
                instr_d <= NOP_INSTR;  // Squash wrong path
            end else begin
                instr_d <= instr_readdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable && !stall_d) begin
            pc_plus4_d <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

// ==== decode/register_file.sv ====
// 32 x 32 register file with write-through reads and v0 tap
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mips_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_enable,
    input  logic      write_enable,
    input  reg_addr_t read_addr_1,
    input  reg_addr_t read_addr_2,
    input  reg_addr_t write_addr,
    input  word_t     write_data,
    output word_t     read_data_1,
    output word_t     read_data_2,
    output word_t     v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && write_enable && write_addr != '0) begin
            regs[write_addr] <= write_data;
        end
    end

    // Same-cycle write is seen by decode
    assign read_data_1 = (read_addr_1 == '0) ? '0 :
                         (write_enable && write_addr == read_addr_1) ? write_data :
                         regs[read_addr_1];
    assign read_data_2 = (read_addr_2 == '0) ? '0 :
                         (write_enable && write_addr == read_addr_2) ? write_data :
                         regs[read_addr_2];

    assign v0 = regs[REG_V0];

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
// Control decoding, branch compare and target, decode/execute register
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_enable,
    input  logic      flush_e,
    input  word_t     instr_d,
    input  word_t     pc_plus4_d,
    input  word_t     read_data_1,
    input  word_t     read_data_2,
    output reg_addr_t read_addr_1,
    output reg_addr_t read_addr_2,
    output logic      pc_src_d,
    output logic      branch_d,
    output logic      halt_d,
    output word_t     branch_target_d,
    output logic      reg_write_e,
    output logic      mem_read_e,
    output logic      mem_write_e,
    output logic      alu_src_imm_e,
    output alu_ctrl_t alu_ctrl_e,
    output word_t     operand_a_e,
    output word_t     operand_b_e,
    output word_t     imm_e,
    output reg_addr_t src_a_e,
    output reg_addr_t src_b_e,
    output reg_addr_t dest_e
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm16_t    imm;
    word_t     imm_ext;
    logic      is_beq;
    logic      is_jr;
    logic      reg_write_d;
    logic      mem_read_d;
    logic      mem_write_d;
    logic      alu_src_imm_d;
    alu_ctrl_t alu_ctrl_d;

    assign opcode  = instr_opcode(instr_d);
    assign funct   = instr_funct(instr_d);
    assign rs      = instr_rs(instr_d);
    assign rt      = instr_rt(instr_d);
    assign rd      = instr_rd(instr_d);
    assign imm     = instr_imm(instr_d);
    assign imm_ext = {{16{imm[15]}}, imm};

    assign read_addr_1 = rs;
    assign read_addr_2 = rt;

    always_comb begin
        reg_write_d   = 1'b0;
        mem_read_d    = 1'b0;
        mem_write_d   = 1'b0;
        alu_src_imm_d = 1'b0;
        alu_ctrl_d    = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                reg_write_d = funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT};
                case (funct)
                    FN_SUBU: alu_ctrl_d = ALU_SUB;
                    FN_AND:  alu_ctrl_d = ALU_AND;
                    FN_OR:   alu_ctrl_d = ALU_OR;
                    FN_SLT:  alu_ctrl_d = ALU_SLT;
                    default: alu_ctrl_d = ALU_ADD;
                endcase
            end
            OP_ADDIU, OP_LUI, OP_LW: begin
                reg_write_d   = 1'b1;
                mem_read_d    = (opcode == OP_LW);
                alu_src_imm_d = 1'b1;
                alu_ctrl_d    = (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
            end
            OP_SW: begin
                mem_write_d   = 1'b1;
                alu_src_imm_d = 1'b1;
            end
            default: ;  // beq and nops carry no execute control
        endcase
    end

    // Branches and jr resolve here, jr $0 stops the core
    assign is_beq   = (opcode == OP_BEQ);
    assign is_jr    = (opcode == OP_RTYPE) && (funct == FN_JR);
    assign branch_d = is_beq || is_jr;
    assign halt_d   = is_jr && (rs == '0);
    assign pc_src_d = (is_beq && read_data_1 == read_data_2) || (is_jr && rs != '0);

    assign branch_target_d = is_jr ? read_data_1 : pc_plus4_d + {imm_ext[29:0], 2'b00};

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_e <= 1'b0;
            mem_read_e  <= 1'b0;
            mem_write_e <= 1'b0;
        end else if (clk_enable) begin
            reg_write_e <= reg_write_d && !flush_e;  // Bubble on flush
            mem_read_e  <= mem_read_d && !flush_e;
            mem_write_e <= mem_write_d && !flush_e;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            alu_src_imm_e <= alu_src_imm_d;
            alu_ctrl_e    <= alu_ctrl_d;
            operand_a_e   <= read_data_1;
            operand_b_e   <= read_data_2;
            imm_e         <= imm_ext;
            src_a_e       <= rs;
            src_b_e       <= rt;
            dest_e        <= (opcode == OP_RTYPE) ? rd : rt;
        end
    end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
// Forwarding, ALU, data bus drive, execute/writeback register and activity flag
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import mips_isa_pkg::*, mips_pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      clk_enable,
    input  logic      reg_write_e,
    input  logic      mem_read_e,
    input  logic      mem_write_e,
    input  logic      alu_src_imm_e,
    input  alu_ctrl_t alu_ctrl_e,
    input  word_t     operand_a_e,
    input  word_t     operand_b_e,
    input  word_t     imm_e,
    input  reg_addr_t src_a_e,
    input  reg_addr_t src_b_e,
    input  reg_addr_t dest_e,
    input  word_t     data_readdata,
    output word_t     data_address,
    output word_t     data_writedata,
    output logic      data_read,
    output logic      data_write,
    output logic      reg_write_w,
    output reg_addr_t write_reg_w,
    output word_t     result_w,
    output reg_addr_t write_reg_e,
    input  logic      running,
    output logic      active
);

    logic  fwd_a;
    logic  fwd_b;
    word_t src_a;
    word_t src_b;
    word_t alu_b;
    word_t alu_result;

    // Bypass from the writeback register
    assign fwd_a = reg_write_w && (write_reg_w != '0) && (write_reg_w == src_a_e);
    assign fwd_b = reg_write_w && (write_reg_w != '0) && (write_reg_w == src_b_e);
    assign src_a = fwd_a ? result_w : operand_a_e;
    assign src_b = fwd_b ? result_w : operand_b_e;
    assign alu_b = alu_src_imm_e ? imm_e : src_b;

    always_comb begin
        case (alu_ctrl_e)
            ALU_SUB: alu_result = src_a - alu_b;
            ALU_AND: alu_result = src_a & alu_b;
            ALU_OR:  alu_result = src_a | alu_b;
            ALU_SLT: alu_result = {31'b0, $signed(src_a) < $signed(alu_b)};
            ALU_LUI: alu_result = {alu_b[15:0], 16'h0000};
            default: alu_result = src_a + alu_b;
        endcase
    end

    assign data_address   = alu_result;
    assign data_writedata = src_b;  // Store data is rt
    assign data_read      = mem_read_e;
    assign data_write     = mem_write_e;

    // Zero when nothing is written, seen by the hazard unit
    assign write_reg_e = reg_write_e ? dest_e : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_write_w <= 1'b0;
        end else if (clk_enable) begin
            reg_write_w <= reg_write_e;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_enable) begin
            write_reg_w <= dest_e;
            result_w    <= mem_read_e ? data_readdata : alu_result;
        end
    end

    // Stays high until fetch halted and both registers drained
    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b1;
        end else if (clk_enable) begin
            active <= running || reg_write_e || mem_write_e || reg_write_w;
        end
    end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
// Branch dependency stall and execute bubble
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import mips_isa_pkg::*;
(
    input  logic      branch_d,
    input  reg_addr_t src_1_d,
    input  reg_addr_t src_2_d,
    input  logic      reg_write_e,
    input  reg_addr_t write_reg_e,
    output logic      stall_f,
    output logic      stall_d,
    output logic      flush_e
);

    logic depends_on_e;

    // Other operands are covered by forwarding and the write-through file
    assign depends_on_e = reg_write_e && (write_reg_e != '0) &&
                          (write_reg_e == src_1_d || write_reg_e == src_2_d);

    assign stall_f = branch_d && depends_on_e;
    assign stall_d = stall_f;
    assign flush_e = stall_f;  // Bubble while the branch waits

endmodule

`default_nettype wire

// ==== source/mips_cpu.sv ====
// Top level of the pipelined core with its Harvard bus
`timescale 1ns/1ps
`default_nettype none

module mips_cpu
    import mips_isa_pkg::*, mips_pipe_pkg::*;
#(
    parameter word_t RESET_PC = RESET_VECTOR
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  clk_enable,
    output logic  active,
    output word_t register_v0,

    output word_t instr_address,
    input  word_t instr_readdata,

    output word_t data_address,
    output logic  data_write,
    output logic  data_read,
    output word_t data_writedata,
    input  word_t data_readdata
);

    // Fetch and decode
    word_t     instr_d;
    word_t     pc_plus4_d;
    word_t     branch_target_d;
    logic      pc_src_d;
    logic      branch_d;
    logic      halt_d;
    logic      running;
    reg_addr_t read_addr_1;
    reg_addr_t read_addr_2;
    word_t     read_data_1;
    word_t     read_data_2;

    // Decode/execute register
    logic      reg_write_e;
    logic      mem_read_e;
    logic      mem_write_e;
    logic      alu_src_imm_e;
    alu_ctrl_t alu_ctrl_e;
    word_t     operand_a_e;
    word_t     operand_b_e;
    word_t     imm_e;
    reg_addr_t src_a_e;
    reg_addr_t src_b_e;
    reg_addr_t dest_e;
    reg_addr_t write_reg_e;

    // Writeback
    logic      reg_write_w;
    reg_addr_t write_reg_w;
    word_t     result_w;

    logic      stall_f;
    logic      stall_d;
    logic      flush_e;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (.*);

    register_file u_register_file (
        .clk         (clk),
        .reset       (reset),
        .clk_enable  (clk_enable),
        .write_enable(reg_write_w),
        .read_addr_1 (read_addr_1),
        .read_addr_2 (read_addr_2),
        .write_addr  (write_reg_w),
        .write_data  (result_w),
        .read_data_1 (read_data_1),
        .read_data_2 (read_data_2),
        .v0          (register_v0)
    );

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    hazard_unit u_hazard (
        .branch_d   (branch_d),
        .src_1_d    (read_addr_1),
        .src_2_d    (read_addr_2),
        .reg_write_e(reg_write_e),
        .write_reg_e(write_reg_e),
        .stall_f    (stall_f),
        .stall_d    (stall_d),
        .flush_e    (flush_e)
    );

endmodule

`default_nettype wire

// ==== bench/mips_cpu_tb.sv ====
// Core testbench with memory models, program table, run loop and checks
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_tb
    import mips_isa_pkg::*, mips_pipe_pkg::*;
();

    localparam int    NUM_TESTS      = 6;
    localparam int    PROG_WORDS     = 16;
    localparam int    DMEM_WORDS     = 64;
    localparam int    TIMEOUT_CYCLES = 64 * NUM_TESTS;
    localparam int    RANDOM_SEED    = 51507;
    localparam int    CHECK_INDEX    = 32'h10 / 4;  // Word holding address 0x10
    localparam word_t RESET_PC       = RESET_VECTOR;
    localparam word_t FILL_BASE      = 32'hC0DE_0000;
    localparam word_t IDLE_READ      = 32'hDEAD_BEEF;  // Bus value while no load is made

    logic  clk;
    logic  reset;
    logic  clk_enable;
    logic  active;
    word_t register_v0;
    word_t instr_address;
    word_t instr_readdata;
    word_t data_address;
    logic  data_write;
    logic  data_read;
    word_t data_writedata;
    word_t data_readdata;

    word_t imem [PROG_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t imem_offset;

    // Program table
    string test_name [NUM_TESTS];
    word_t program_words [NUM_TESTS][PROG_WORDS];
    word_t expect_v0 [NUM_TESTS];
    word_t expect_mem [NUM_TESTS];
    logic  random_enable [NUM_TESTS];

    int cycle_count = 0;

    mips_cpu #(
        .RESET_PC(RESET_PC)
    ) mips_cpu_i (
        .clk           (clk),
        .reset         (reset),
        .clk_enable    (clk_enable),
        .active        (active),
        .register_v0   (register_v0),
        .instr_address (instr_address),
        .instr_readdata(instr_readdata),
        .data_address  (data_address),
        .data_write    (data_write),
        .data_read     (data_read),
        .data_writedata(data_writedata),
        .data_readdata (data_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction memory starts at RESET_PC and returns nops outside the program
    assign imem_offset    = instr_address - RESET_PC;
    assign instr_readdata = (imem_offset < PROG_WORDS * 4) ? imem[imem_offset[5:2]] : NOP_INSTR;
    assign data_readdata  = data_read ? dmem[data_address[7:2]] : IDLE_READ;

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the programs did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    function automatic word_t r_format(input reg_addr_t rs, input reg_addr_t rt,
                                       input reg_addr_t rd, input funct_t fn);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_format(input opcode_t op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic choose_clk_enable(input int t);
        return random_enable[t] ? (($urandom % 3) != 0) : 1'b1;
    endfunction

    task automatic stop_with_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic set_expected(input int t, input string name, input word_t v0,
                                input word_t mem, input logic rnd);
        test_name[t]     = name;
        expect_v0[t]     = v0;
        expect_mem[t]    = mem;
        random_enable[t] = rnd;
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            for (int i = 0; i < PROG_WORDS; i++) begin
                program_words[t][i] = NOP_INSTR;
            end
        end

        // Back to back ALU ops where each result feeds the next
        set_expected(0, "alu_ops", 32'h1234_0007, FILL_BASE ^ 32'h10, 1'b0);
        program_words[0][0]  = i_format(OP_ADDIU, 5'd0, 5'd8, 16'd5);      // $8 = 5
        program_words[0][1]  = i_format(OP_ADDIU, 5'd0, 5'd9, 16'hFFFD);   // $9 = -3
        program_words[0][2]  = r_format(5'd8, 5'd9, 5'd10, FN_ADDU);       // 2
        program_words[0][3]  = r_format(5'd8, 5'd9, 5'd11, FN_SUBU);       // 8
        program_words[0][4]  = r_format(5'd10, 5'd11, 5'd12, FN_OR);       // 0xA
        program_words[0][5]  = r_format(5'd12, 5'd9, 5'd13, FN_AND);       // 0x8
        program_words[0][6]  = r_format(5'd9, 5'd8, 5'd14, FN_SLT);        // 1
        program_words[0][7]  = i_format(OP_LUI, 5'd0, 5'd15, 16'h1234);
        program_words[0][8]  = r_format(5'd15, 5'd13, REG_V0, FN_OR);      // 0x12340008
        program_words[0][9]  = r_format(REG_V0, 5'd14, REG_V0, FN_ADDU);   // 0x12340009
        program_words[0][10] = r_format(REG_V0, 5'd10, REG_V0, FN_SUBU);   // 0x12340007
        program_words[0][11] = r_format(5'd0, 5'd0, 5'd0, FN_JR);

        // Store then load back right away and add
        set_expected(1, "load_store", 32'h0000_00EE, 32'h0000_0077, 1'b0);
        program_words[1][0] = i_format(OP_ADDIU, 5'd0, 5'd8, 16'h0077);
        program_words[1][1] = i_format(OP_ADDIU, 5'd0, 5'd9, 16'h0010);
        program_words[1][2] = i_format(OP_SW, 5'd9, 5'd8, 16'd0);
        program_words[1][3] = i_format(OP_LW, 5'd9, 5'd10, 16'd0);
        program_words[1][4] = r_format(5'd10, 5'd8, REG_V0, FN_ADDU);
        program_words[1][5] = r_format(5'd0, 5'd0, 5'd0, FN_JR);

        set_expected(2, "branch_taken_untaken", 32'h0000_1010, FILL_BASE ^ 32'h10, 1'b0);
        program_words[2][0] = i_format(OP_ADDIU, 5'd0, 5'd8, 16'd1);
        program_words[2][1] = i_format(OP_ADDIU, 5'd0, 5'd9, 16'd1);
        program_words[2][2] = i_format(OP_ADDIU, 5'd0, 5'd10, 16'd7);
        program_words[2][3] = i_format(OP_BEQ, 5'd8, 5'd0, 16'd1);         // Not taken
        program_words[2][4] = i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0010);
        program_words[2][5] = i_format(OP_BEQ, 5'd8, 5'd9, 16'd1);         // Taken
        program_words[2][6] = i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0100); // Squashed
        program_words[2][7] = i_format(OP_ADDIU, REG_V0, REG_V0, 16'h1000);
        program_words[2][8] = r_format(5'd0, 5'd0, 5'd0, FN_JR);

        // Branches reading the register written just before
        set_expected(3, "branch_stall", 32'h0000_0321, FILL_BASE ^ 32'h10, 1'b0);
        program_words[3][0] = i_format(OP_ADDIU, 5'd0, 5'd8, 16'd3);
        program_words[3][1] = i_format(OP_ADDIU, 5'd0, 5'd9, 16'd3);
        program_words[3][2] = i_format(OP_BEQ, 5'd8, 5'd9, 16'd1);         // Taken
        program_words[3][3] = i_format(OP_ADDIU, 5'd0, REG_V0, 16'h0BAD);
        program_words[3][4] = i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0021);
        program_words[3][5] = i_format(OP_ADDIU, 5'd0, 5'd10, 16'd4);
        program_words[3][6] = i_format(OP_BEQ, 5'd10, 5'd8, 16'd1);        // Not taken
        program_words[3][7] = i_format(OP_ADDIU, REG_V0, REG_V0, 16'h0300);
        program_words[3][8] = r_format(5'd0, 5'd0, 5'd0, FN_JR);

        set_expected(4, "random_enable", 32'h0000_00EE, 32'h0000_0077, 1'b1);
        for (int i = 0; i < PROG_WORDS; i++) begin
            program_words[4][i] = program_words[1][i];
        end

        // Nothing after jr $0 may reach memory or v0
        set_expected(5, "halt", 32'h0000_0066, 32'h0000_0055, 1'b0);
        program_words[5][0] = i_format(OP_ADDIU, 5'd0, 5'd8, 16'h0055);
        program_words[5][1] = i_format(OP_SW, 5'd0, 5'd8, 16'h0010);
        program_words[5][2] = i_format(OP_ADDIU, 5'd0, REG_V0, 16'h0066);
        program_words[5][3] = r_format(5'd0, 5'd0, 5'd0, FN_JR);
        program_words[5][4] = i_format(OP_SW, 5'd0, REG_V0, 16'h0010);
        program_words[5][5] = i_format(OP_ADDIU, 5'd0, REG_V0, 16'h0099);
    endtask

    task automatic load_memories(input int t);
        for (int i = 0; i < PROG_WORDS; i++) begin
            imem[i] = program_words[t][i];
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = FILL_BASE ^ word_t'(i * 4);  // Byte address in the low bits
        end
    endtask

    task automatic run_test(input int t);
        $display("Running %s", test_name[t]);
        load_memories(t);
        @(posedge clk);
        reset      <= 1'b1;
        clk_enable <= 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_equal($sformatf("%s active after reset", test_name[t]), 32'd1, word_t'(active));
        check_equal($sformatf("%s data_read after reset", test_name[t]), 32'd0,
                    word_t'(data_read));
        check_equal($sformatf("%s data_write after reset", test_name[t]), 32'd0,
                    word_t'(data_write));

        while (active) begin
            @(posedge clk);
            clk_enable <= choose_clk_enable(t);
            @(negedge clk);
        end

        // Halted core stays quiet
        repeat (10) begin
            @(posedge clk);
            clk_enable <= choose_clk_enable(t);
            @(negedge clk);
            check_equal($sformatf("%s active after halt", test_name[t]), 32'd0,
                        word_t'(active));
            check_equal($sformatf("%s mem[0x10] after halt", test_name[t]), expect_mem[t],
                        dmem[CHECK_INDEX]);
        end

        check_equal($sformatf("%s v0", test_name[t]), expect_v0[t], register_v0);
        check_equal($sformatf("%s mem[0x10]", test_name[t]), expect_mem[t], dmem[CHECK_INDEX]);
    endtask

    initial begin
        reset      = 1'b1;
        clk_enable = 1'b1;
        void'($urandom(RANDOM_SEED));
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_cpu.f ====
common/mips_isa_pkg.sv
common/mips_pipe_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
source/hazard_unit.sv
source/mips_cpu.sv
bench/mips_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: mips_cpu

sources:
  - common/mips_isa_pkg.sv
  - common/mips_pipe_pkg.sv
  - fetch/fetch_stage.sv
  - decode/register_file.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - source/hazard_unit.sv
  - source/mips_cpu.sv
  - target: simulation
    files:
      - bench/mips_cpu_tb.sv
